//--- files.f
verilog/clmul_pkg.sv
verilog/karatsuba_split.sv
verilog/serial_clmul.sv
verilog/karatsuba_combine.sv
verilog/karatsuba_mul_top.sv
tb/karatsuba_mul_sva.sv
tb/karatsuba_mul_tb.sv

//--- Makefile
# Verilator build for the Karatsuba carry-less multiplier

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= karatsuba_mul_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail decided by the pass line in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/karatsuba_mul_tb.sv
// Testbench for the Karatsuba carry-less multiplier
// Table of operand pairs checked against a schoolbook GF(2) model,
// with latency, busy window and product hold checks

`default_nettype none
`timescale 1ns/1ps

module karatsuba_mul_tb;

	localparam int WIDTH          = 37;
	localparam int HALF           = (WIDTH + 1) / 2;
	localparam int PW             = 2 * WIDTH - 1;
	localparam int CLK_PERIOD     = 40;
	localparam int RST_CYCLES     = 5;
	localparam int N_ROWS         = 16;
	localparam int LATENCY        = HALF + 2;
	localparam int IDLE_CYCLES    = 8;
	localparam int TIMEOUT_CYCLES = N_ROWS * (HALF + 6) + RST_CYCLES;

	logic             clk;
	logic             rst;
	logic             start;
	logic [WIDTH-1:0] a;
	logic [WIDTH-1:0] b;
	logic             busy;
	logic             done;
	logic [PW-1:0]    product;

	// Stimulus table with expected products
	logic [WIDTH-1:0] tab_a [N_ROWS];
	logic [WIDTH-1:0] tab_b [N_ROWS];
	logic             tab_retry [N_ROWS];
	logic [PW-1:0]    tab_exp [N_ROWS];

	logic [31:0]      lfsr;
	logic [PW-1:0]    last_product;

	karatsuba_mul_top #(
		.WIDTH(WIDTH)
	) i_karatsuba_mul_top (
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.a       (a),
		.b       (b),
		.busy    (busy),
		.done    (done),
		.product (product)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Galois LFSR for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
	endfunction

	// One LFSR step per operand bit
	task automatic random_operand(output logic [WIDTH-1:0] v);
		for (int i = 0; i < WIDTH; i++) begin
			lfsr = lfsr_next(lfsr);
			v[i] = lfsr[0];
		end
	endtask

	// Schoolbook product over GF(2)
	function automatic logic [PW-1:0] clmul_model(input logic [WIDTH-1:0] x,
		input logic [WIDTH-1:0] y);
		logic [PW-1:0] acc;
		acc = '0;
		for (int i = 0; i < WIDTH; i++) begin
			for (int j = 0; j < WIDTH; j++) begin
				acc[i + j] = acc[i + j] ^ (x[i] & y[j]);
			end
		end
		return acc;
	endfunction

	task automatic check_equal(input string name, input logic [PW-1:0] got,
		input logic [PW-1:0] expected);
		if (got !== expected) begin
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got,
				expected);
			$display("Some tests failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic build_table();
		for (int r = 0; r < N_ROWS; r++) begin
			tab_retry[r] = 1'b0;
		end
		tab_a[0] = '0;
		tab_b[0] = '0;
		tab_a[1] = '1;
		tab_b[1] = '1;
		// Single bits at both ends and around the split
		tab_a[2] = WIDTH'(1);
		tab_b[2] = WIDTH'(1) << (WIDTH - 1);
		tab_a[3] = WIDTH'(1) << (WIDTH - 1);
		tab_b[3] = WIDTH'(1) << (WIDTH - 1);
		tab_a[4] = WIDTH'(1) << (HALF - 1);
		tab_b[4] = WIDTH'(1) << HALF;
		tab_a[5] = WIDTH'(1) << HALF;
		tab_b[5] = WIDTH'(1) << HALF;
		// Rows 6 and 7 differ only above the split
		tab_a[6] = 37'h0a_c35a_1e47;
		tab_b[6] = 37'h13_9d0e_62b5;
		tab_a[7] = tab_a[6] ^ {18'h2d3c1, {HALF{1'b0}}};
		tab_b[7] = tab_b[6] ^ {18'h1b0e6, {HALF{1'b0}}};
		for (int r = 8; r < N_ROWS; r++) begin
			random_operand(tab_a[r]);
			random_operand(tab_b[r]);
		end
		tab_retry[2]  = 1'b1;
		tab_retry[7]  = 1'b1;
		tab_retry[9]  = 1'b1;
		tab_retry[14] = 1'b1;
		for (int r = 0; r < N_ROWS; r++) begin
			tab_exp[r] = clmul_model(tab_a[r], tab_b[r]);
		end
	endtask

	// Launch one row and follow it cycle by cycle until done
	task automatic run_row(input int r);
		int cycles;
		cycles = 0;
		check_equal("busy before start", PW'(busy), '0);
		@(posedge clk);
		start <= 1'b1;
		a     <= tab_a[r];
		b     <= tab_b[r];
		while (done !== 1'b1) begin
			@(posedge clk);
			if (tab_retry[r] && cycles == LATENCY - 1) begin
				// Second start in the last busy cycle is dropped
				start <= 1'b1;
				a     <= ~tab_a[r];
				b     <= ~tab_b[r];
			end else begin
				start <= 1'b0;
			end
			@(negedge clk);
			cycles++;
			if (done !== 1'b1) begin
				check_equal("busy", PW'(busy), PW'(1));
				check_equal("product", product, last_product);
			end
		end
		check_equal("done latency", PW'(cycles), PW'(LATENCY + 1));
		check_equal("busy at done", PW'(busy), '0);
		check_equal("product", product, tab_exp[r]);
		last_product = tab_exp[r];
		@(negedge clk);
		check_equal("done width", PW'(done), '0);
		check_equal("busy after done", PW'(busy), '0);
		check_equal("product hold", product, last_product);
	endtask

	initial begin
		rst          = 1'b1;
		start        = 1'b0;
		a            = '0;
		b            = '0;
		lfsr         = 32'hd959;
		last_product = '0;
		build_table();
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_equal("busy after reset", PW'(busy), '0);
		check_equal("done after reset", PW'(done), '0);
		check_equal("product after reset", product, '0);
		for (int r = 0; r < N_ROWS; r++) begin
			run_row(r);
		end
		// Product stays put with no further starts
		repeat (IDLE_CYCLES) begin
			@(negedge clk);
			check_equal("done idle", PW'(done), '0);
			check_equal("product idle", product, last_product);
		end
		$display("All tests passed");
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout: the multiplier did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

//--- tb/karatsuba_mul_sva.sv
// Strobe assertions for the Karatsuba multiplier top level
// Bound to karatsuba_mul_top

`default_nettype none
`timescale 1ns/1ps

module karatsuba_mul_sva (
	input logic clk,
	input logic rst,
	input logic start,
	input logic busy,
	input logic done
);

	// done is a single-cycle pulse
	a_done_pulse: assert property (@(posedge clk) disable iff (rst)
		done |=> !done)
		else $error("done high for two cycles in a row");

	// done only rises at the end of a busy window
	a_done_in_busy: assert property (@(posedge clk) disable iff (rst)
		$rose(done) |-> $past(busy))
		else $error("done rose while busy was low");

	// Accepted start
	a_start_busy: assert property (@(posedge clk) disable iff (rst)
		(start && !busy) |=> busy)
		else $error("busy not raised after an accepted start");

endmodule

bind karatsuba_mul_top karatsuba_mul_sva i_sva (
	.clk   (clk),
	.rst   (rst),
	.start (start),
	.busy  (busy),
	.done  (done)
);

`default_nettype wire

//--- verilog/karatsuba_mul_top.sv
// Two-way Karatsuba carry-less multiplier, top level
// Splitter feeds three identical bit-serial cores, combiner drains them
// Fixed latency of HALF+2 cycles from accepted start to done

`default_nettype none
`timescale 1ns/1ps

module karatsuba_mul_top #(
	parameter int WIDTH = 571
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  logic [WIDTH-1:0]   a,
	input  logic [WIDTH-1:0]   b,
	output logic               busy,
	output logic               done,
	output logic [2*WIDTH-2:0] product
);

	import clmul_pkg::*;

	localparam int HALF = (WIDTH + 1) / 2;

	logic                 core_start;
	logic                 clear_busy;
	logic [HALF-1:0]      x_op [NUM_PARTS];
	logic [HALF-1:0]      y_op [NUM_PARTS];
	logic [NUM_PARTS-1:0] core_done;
	logic [2*HALF-2:0]    partial [NUM_PARTS];

	karatsuba_split #(
		.WIDTH(WIDTH)
	) i_split (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.a          (a),
		.b          (b),
		.clear_busy (clear_busy),
		.busy       (busy),
		.core_start (core_start),
		.x_op       (x_op),
		.y_op       (y_op)
	);

	// One core per Karatsuba part
	for (genvar p = 0; p < NUM_PARTS; p++) begin : g_core
		localparam part_sel_t PART = part_sel_t'(p);

		serial_clmul #(
			.OP_WIDTH(HALF)
		) i_core (
			.clk        (clk),
			.rst        (rst),
			.core_start (core_start),
			.x_op       (x_op[PART]),
			.y_op       (y_op[PART]),
			.core_done  (core_done[PART]),
			.partial    (partial[PART])
		);
	end

	karatsuba_combine #(
		.WIDTH(WIDTH)
	) i_combine (
		.clk        (clk),
		.rst        (rst),
		.core_done  (core_done),
		.partial    (partial),
		.clear_busy (clear_busy),
		.done       (done),
		.product    (product)
	);

endmodule

`default_nettype wire

//--- verilog/karatsuba_combine.sv
// Karatsuba recombination
// Waits for all three cores, forms the middle term and assembles the
// full carry-less product, then raises done for one cycle

`default_nettype none
`timescale 1ns/1ps

module karatsuba_combine #(
	parameter int WIDTH = 571,
	localparam int HALF = (WIDTH + 1) / 2
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [clmul_pkg::NUM_PARTS-1:0] core_done,
	input  logic [2*HALF-2:0]             partial [clmul_pkg::NUM_PARTS],
	output logic                          clear_busy,
	output logic                          done,
	output logic [2*WIDTH-2:0]            product
);

	import clmul_pkg::*;

	// Assembly width before truncation, covers the high part at bit 2*HALF
	localparam int FULL_W = 4 * HALF - 1;

	logic              all_done;
	logic [2*HALF-2:0] mid_term;
	logic [FULL_W-1:0] hi_term;
	logic [FULL_W-1:0] md_term;
	logic [FULL_W-1:0] lo_term;
	logic [FULL_W-1:0] full_sum;

	// Cores run in lockstep, so their done pulses coincide
	assign all_done = &core_done;

	// Subtraction in GF(2) is XOR
	assign mid_term = partial[PART_MID] ^ partial[PART_HIGH] ^ partial[PART_LOW];

	assign hi_term  = FULL_W'(partial[PART_HIGH]) << (2 * HALF);
	assign md_term  = FULL_W'(mid_term) << HALF;
	assign lo_term  = FULL_W'(partial[PART_LOW]);
	assign full_sum = hi_term ^ md_term ^ lo_term;

	// Busy drops on the edge that registers the product
	assign clear_busy = all_done;

	always_ff @(posedge clk) begin
		if (rst) begin
			done    <= 1'b0;
			product <= '0;
		end else begin
			done <= all_done;
			if (all_done) begin
				// Bits above 2*WIDTH-2 are zero for a valid product
				product <= full_sum[2*WIDTH-2:0];
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/serial_clmul.sv
// Bit-serial carry-less multiplier
// Shift-and-XOR over GF(2), one multiplier bit per clock,
// OP_WIDTH steps after the load cycle

`default_nettype none
`timescale 1ns/1ps

module serial_clmul #(
	parameter int OP_WIDTH = 286
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  core_start,
	input  logic [OP_WIDTH-1:0]   x_op,
	input  logic [OP_WIDTH-1:0]   y_op,
	output logic                  core_done,
	output logic [2*OP_WIDTH-2:0] partial
);

	import clmul_pkg::*;

	localparam int PROD_W = 2 * OP_WIDTH - 1;
	localparam int CNT_W  = $clog2(OP_WIDTH + 1);

	core_state_t        state;
	logic [CNT_W-1:0]   step;
	logic [OP_WIDTH-1:0] mult_sr;
	logic [PROD_W-1:0]  mcand;
	logic [PROD_W-1:0]  acc;
	logic               last_step;

	assign last_step = (step == CNT_W'(OP_WIDTH - 1));

	// FSM and step counter
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= CORE_IDLE;
			step      <= '0;
			core_done <= 1'b0;
		end else begin
			core_done <= 1'b0;
			case (state)
				CORE_IDLE: begin
					if (core_start) begin
						state <= CORE_RUN;
						step  <= '0;
					end
				end
				CORE_RUN: begin
					step <= step + 1'b1;
					if (last_step) begin
						state     <= CORE_IDLE;
						core_done <= 1'b1;
					end
				end
				default: state <= CORE_IDLE;
			endcase
		end
	end

	// Datapath
	always_ff @(posedge clk) begin
		if (state == CORE_IDLE && core_start) begin
			mult_sr <= y_op;
			mcand   <= PROD_W'(x_op);
			acc     <= '0;
		end else if (state == CORE_RUN) begin
			// Add the shifted multiplicand when the current multiplier bit is set
			if (mult_sr[0]) begin
				acc <= acc ^ mcand;
			end
			mult_sr <= mult_sr >> 1;
			mcand   <= mcand << 1;
		end
	end

	// Accumulator is final once core_done rises and holds until the next load
	assign partial = acc;

endmodule

`default_nettype wire

//--- verilog/karatsuba_split.sv
// Karatsuba operand splitter
// Accepts a start while idle, registers the half operands and their
// sums, launches the cores and owns the busy flag

`default_nettype none
`timescale 1ns/1ps

module karatsuba_split #(
	parameter int WIDTH = 571,
	localparam int HALF = (WIDTH + 1) / 2
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	input  logic             clear_busy,
	output logic             busy,
	output logic             core_start,
	output logic [HALF-1:0]  x_op [clmul_pkg::NUM_PARTS],
	output logic [HALF-1:0]  y_op [clmul_pkg::NUM_PARTS]
);

	import clmul_pkg::*;

	logic            accept;
	logic [HALF-1:0] a_hi;
	logic [HALF-1:0] a_lo;
	logic [HALF-1:0] b_hi;
	logic [HALF-1:0] b_lo;

	// A start during a running multiply is dropped
	assign accept = start & ~busy;

	// Low half is the rounded-up half, high half zero-extended for odd widths
	assign a_lo = a[HALF-1:0];
	assign b_lo = b[HALF-1:0];
	assign a_hi = HALF'(a >> HALF);
	assign b_hi = HALF'(b >> HALF);

	// Control
	always_ff @(posedge clk) begin
		if (rst) begin
			busy       <= 1'b0;
			core_start <= 1'b0;
		end else begin
			core_start <= accept;
			if (accept) begin
				busy <= 1'b1;
			end else if (clear_busy) begin
				busy <= 1'b0;
			end
		end
	end

	// Operand registers, only written while idle
	always_ff @(posedge clk) begin
		if (accept) begin
			x_op[PART_HIGH] <= a_hi;
			x_op[PART_LOW]  <= a_lo;
			x_op[PART_MID]  <= a_hi ^ a_lo;
			y_op[PART_HIGH] <= b_hi;
			y_op[PART_LOW]  <= b_lo;
			y_op[PART_MID]  <= b_hi ^ b_lo;
		end
	end

endmodule

`default_nettype wire

//--- verilog/clmul_pkg.sv
// Carry-less Karatsuba multiplier shared definitions
// Part names for the three partial products and the core FSM states

`default_nettype none

package clmul_pkg;

	// Number of partial products in one Karatsuba level
	localparam int NUM_PARTS = 3;

	// Karatsuba parts, also used as the core index
	//   PART_HIGH  a_hi * b_hi
	//   PART_LOW   a_lo * b_lo
	//   PART_MID   (a_hi ^ a_lo) * (b_hi ^ b_lo)
	typedef enum logic [1:0] {
		PART_HIGH = 2'd0,
		PART_LOW  = 2'd1,
		PART_MID  = 2'd2
	} part_sel_t;

	// Bit-serial core FSM
	typedef enum logic {
		CORE_IDLE = 1'b0,
		CORE_RUN  = 1'b1
	} core_state_t;

endpackage

`default_nettype wire
